//--- hazardUnit.f
+incdir+.
hazardPkg.sv
hazardDecode.sv
hazardExecute.sv
hazardResult.sv
hazardUnit.sv
hazardUnit_asserts.sv
hazardUnitTb.sv

//--- Makefile
TOP = hazardUnitTb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f hazardUnit.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf obj_dir

//--- hazardUnitTb.sv
`timescale 1ns/1ns
`include "hazard_defines.svh"

module hazardUnitTb;
    import hazardPkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int MAX_CYCLES = 2000;
    localparam int NUM_RANDOM = 1900;

    logic      clk;
    logic      rst;
    instrT     instrD;
    instrT     instrE;
    logic      regWriteE;
    logic      regWriteM;
    logic      mduBusy;
    logic      mduStart;
    logic      pcWrite;
    logic      ifIdEn;
    logic      idExClr;
    logic      mduClr;
    regNumT    useRs;
    regNumT    useRt;
    stageTimeT tNewE;
    stageTimeT tNewM;

    integer    seed = 78;
    int        bitErrors = 0;
    int        regErrors = 0;
    int        timeErrors = 0;

    // Model copy of the memory-stage record
    regNumT    modelNewM = 5'd0;
    stageTimeT modelTNewM = 2'd0;

    // R-type weighted up with the last two opcodes unsupported
    opcodeT opList [19] = '{`OP_RTYPE, `OP_RTYPE, `OP_RTYPE, `OP_ORI, `OP_ADDI, `OP_ANDI,
                            `OP_LUI, `OP_SW, `OP_SB, `OP_SH, `OP_LW, `OP_LB, `OP_LH,
                            `OP_BEQ, `OP_BNE, `OP_JAL, `OP_J, 6'b111111, 6'b010001};
    functT  fnList [18] = '{`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU,
                            `FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_MFHI, `FN_MFLO,
                            `FN_MTHI, `FN_MTLO, `FN_MULTC, `FN_JR, 6'b000000, 6'b111111};
    functT  probeFn [4] = '{`FN_MULT, `FN_MFHI, `FN_MTHI, `FN_MULTC};

    hazardUnit UUT (
        .clk       (clk),
        .rst       (rst),
        .instrD    (instrD),
        .instrE    (instrE),
        .regWriteE (regWriteE),
        .regWriteM (regWriteM),
        .mduBusy   (mduBusy),
        .mduStart  (mduStart),
        .pcWrite   (pcWrite),
        .ifIdEn    (ifIdEn),
        .idExClr   (idExClr),
        .mduClr    (mduClr),
        .useRs     (useRs),
        .useRt     (useRt),
        .tNewE     (tNewE),
        .tNewM     (tNewM)
    );

    bind hazardUnit hazardUnit_asserts outputChecks (
        .clk     (clk),
        .rst     (rst),
        .pcWrite (pcWrite),
        .ifIdEn  (ifIdEn),
        .idExClr (idExClr),
        .tNewE   (tNewE),
        .tNewM   (tNewM)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(MAX_CYCLES * CLK_PERIOD + 200);
        $display("Watchdog expired before the tests completed");
        $display("RESULT: FAIL");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Compare tasks
    //////////////////////////////////////////////////////////////////////
    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %b, expected %b", $time, name, actual, expected);
            bitErrors++;
        end
    endtask

    task automatic checkReg(input string name, input regNumT actual, input regNumT expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            regErrors++;
        end
    endtask

    task automatic checkTime(input string name, input stageTimeT actual,
                             input stageTimeT expected);
        if (actual !== expected) begin
            $display("ERROR at %0t: %s is %0d, expected %0d", $time, name, actual, expected);
            timeErrors++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Reference tables
    //////////////////////////////////////////////////////////////////////
    // {rs read, Tuse rs, rt read, Tuse rt}
    function automatic logic [5:0] useCode(input instrT instr);
        logic [5:0] code;
        code = 6'b0_00_0_00;
        if (instr[31:26] == `OP_RTYPE) begin
            case (instr[5:0])
                `FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU, `FN_MULT,
                `FN_MULTU, `FN_DIV, `FN_DIVU, `FN_MULTC: code = 6'b1_01_1_01;
                `FN_MTHI, `FN_MTLO:                      code = 6'b1_01_0_00;
                `FN_JR:                                  code = 6'b1_00_0_00;
                default:                                 code = 6'b0_00_0_00;
            endcase
        end else begin
            case (instr[31:26])
                `OP_ORI, `OP_ADDI, `OP_ANDI,
                `OP_LW, `OP_LB, `OP_LH:      code = 6'b1_01_0_00;
                `OP_SW, `OP_SB, `OP_SH:      code = 6'b1_01_1_10;
                `OP_BEQ, `OP_BNE:            code = 6'b1_00_1_00;
                default:                     code = 6'b0_00_0_00;
            endcase
        end
        return code;
    endfunction

    // {destination 0 none, 1 rd, 2 rt, 3 link; Tnew}
    function automatic logic [3:0] produceCode(input instrT instr);
        logic [3:0] code;
        code = 4'b00_00;
        if (instr[31:26] == `OP_RTYPE) begin
            if (instr[5:0] inside {`FN_ADD, `FN_SUB, `FN_AND, `FN_OR, `FN_SLT, `FN_SLTU,
                                   `FN_MFHI, `FN_MFLO}) begin
                code = 4'b01_01;
            end
        end else begin
            case (instr[31:26])
                `OP_ORI, `OP_ADDI, `OP_ANDI, `OP_LUI: code = 4'b10_01;
                `OP_LW, `OP_LB, `OP_LH:               code = 4'b10_10;
                `OP_JAL:                              code = 4'b11_00;
                default:                              code = 4'b00_00;
            endcase
        end
        return code;
    endfunction

    task automatic expectedUse(input instrT instr, output regNumT rs, output stageTimeT tRs,
                               output regNumT rt, output stageTimeT tRt);
        logic [5:0] code;
        code = useCode(instr);
        rs   = code[5] ? instr[25:21] : 5'd0;
        tRs  = code[4:3];
        rt   = code[2] ? instr[20:16] : 5'd0;
        tRt  = code[1:0];
    endtask

    task automatic expectedProduce(input instrT instr, output regNumT dest,
                                   output stageTimeT tNew);
        logic [3:0] code;
        code = produceCode(instr);
        case (code[3:2])
            2'd1:    dest = instr[15:11];
            2'd2:    dest = instr[20:16];
            2'd3:    dest = `LINK_REG;
            default: dest = 5'd0;
        endcase
        tNew = code[1:0];
    endtask

    function automatic logic startsMdu(input instrT instr);
        return (instr[31:26] == `OP_RTYPE) &&
               (instr[5:0] inside {`FN_MULT, `FN_MULTU, `FN_DIV, `FN_DIVU});
    endfunction

    function automatic logic usesHiLo(input instrT instr);
        return (instr[31:26] == `OP_RTYPE) &&
               (instr[5:0] inside {`FN_MFHI, `FN_MFLO, `FN_MTHI, `FN_MTLO, `FN_MULTC});
    endfunction

    function automatic instrT makeR(input functT fn, input regNumT rs, input regNumT rt,
                                    input regNumT rd);
        return {`OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic instrT makeI(input opcodeT op, input regNumT rs, input regNumT rt);
        return {op, rs, rt, 16'd0};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stimulus and checking
    //////////////////////////////////////////////////////////////////////
    task automatic checkOutputs();
        regNumT    expRs;
        regNumT    expRt;
        regNumT    destE;
        stageTimeT useTimeRs;
        stageTimeT useTimeRt;
        stageTimeT expTNewE;
        logic      mduActive;
        logic      dataStall;
        logic      expStall;
        expectedUse(instrD, expRs, useTimeRs, expRt, useTimeRt);
        expectedProduce(instrE, destE, expTNewE);
        dataStall = (expRs != 5'd0 && expRs == destE && regWriteE && useTimeRs < expTNewE)
            || (expRs != 5'd0 && expRs == modelNewM && regWriteM && useTimeRs < modelTNewM)
            || (expRt != 5'd0 && expRt == destE && regWriteE && useTimeRt < expTNewE)
            || (expRt != 5'd0 && expRt == modelNewM && regWriteM && useTimeRt < modelTNewM);
        mduActive = mduBusy || mduStart;
        expStall  = dataStall || (mduActive && usesHiLo(instrD));
        checkReg("useRs", useRs, expRs);
        checkReg("useRt", useRt, expRt);
        checkTime("tNewE", tNewE, expTNewE);
        checkTime("tNewM", tNewM, modelTNewM);
        checkBit("pcWrite", pcWrite, !expStall);
        checkBit("ifIdEn", ifIdEn, !expStall);
        checkBit("idExClr", idExClr, expStall);
        checkBit("mduClr", mduClr, mduActive && startsMdu(instrD));
    endtask

    task automatic driveCycle(input instrT d, input instrT e, input logic weE, input logic weM,
                              input logic busy, input logic start);
        regNumT    destE;
        stageTimeT tNewNow;
        @(posedge clk);
        // Record takes the instruction leaving execute at this edge
        expectedProduce(instrE, destE, tNewNow);
        modelNewM  = rst ? 5'd0 : destE;
        modelTNewM = (rst || tNewNow == 2'd0) ? 2'd0 : tNewNow - 2'd1;
        instrD    <= d;
        instrE    <= e;
        regWriteE <= weE;
        regWriteM <= weM;
        mduBusy   <= busy;
        mduStart  <= start;
        @(negedge clk);
        checkOutputs();
    endtask

    task automatic applyReset();
        rst <= 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        modelNewM  = 5'd0;
        modelTNewM = 2'd0;
        @(negedge clk);
        checkOutputs();
        checkTime("tNewM", tNewM, 2'd0);
        checkBit("pcWrite", pcWrite, 1'b1);
        checkBit("ifIdEn", ifIdEn, 1'b1);
        checkBit("idExClr", idExClr, 1'b0);
        checkBit("mduClr", mduClr, 1'b0);
    endtask

    task automatic randomInstr(output instrT instr);
        int          opIdx;
        int          fnIdx;
        logic [31:0] r;
        opIdx = $unsigned($random(seed)) % 19;
        fnIdx = $unsigned($random(seed)) % 18;
        r     = $random(seed);
        // Registers 0 to 3 only so matches are common
        instr = {opList[opIdx], regNumT'(r[1:0]), regNumT'(r[3:2]), regNumT'(r[5:4]),
                 5'd0, fnList[fnIdx]};
    endtask

    initial begin
        instrT       d;
        instrT       e;
        logic [31:0] r;
        rst       = 1'b1;
        instrD    = '0;
        // Load in execute during reset so the record has a nonzero Tnew to clear
        instrE    = makeI(`OP_LW, 5'd1, 5'd2);
        regWriteE = 1'b0;
        regWriteM = 1'b0;
        mduBusy   = 1'b0;
        mduStart  = 1'b0;
        applyReset();

        // Load into a dependent ALU op
        driveCycle(makeR(`FN_ADD, 5'd2, 5'd1, 5'd3), makeI(`OP_LW, 5'd1, 5'd2),
                   1'b1, 1'b0, 1'b0, 1'b0);
        checkBit("idExClr", idExClr, 1'b1);
        // ALU result is store data and forwards in time
        driveCycle(makeI(`OP_SW, 5'd1, 5'd2), makeR(`FN_ADD, 5'd1, 5'd1, 5'd2),
                   1'b1, 1'b0, 1'b0, 1'b0);
        checkBit("idExClr", idExClr, 1'b0);
        // Register 0 never stalls
        driveCycle(makeR(`FN_ADD, 5'd0, 5'd0, 5'd3), makeI(`OP_LW, 5'd1, 5'd0),
                   1'b1, 1'b1, 1'b0, 1'b0);
        checkBit("idExClr", idExClr, 1'b0);

        // Busy and start against each MDU class
        for (int k = 0; k < 16; k++) begin
            d = makeR(probeFn[k / 4], 5'd1, 5'd2, 5'd3);
            driveCycle(d, '0, 1'b0, 1'b0, k[1], k[0]);
        end

        repeat (NUM_RANDOM) begin
            randomInstr(d);
            randomInstr(e);
            r = $random(seed);
            driveCycle(d, e, r[0], r[1], r[2], r[3]);
        end

        $display("Error counts: bit %0d, register %0d, time %0d",
                 bitErrors, regErrors, timeErrors);
        if (bitErrors + regErrors + timeErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- hazardUnit_asserts.sv
`timescale 1ns/1ns

module hazardUnit_asserts (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  pcWrite,
    input  logic                  ifIdEn,
    input  logic                  idExClr,
    input  hazardPkg::stageTimeT  tNewE,
    input  hazardPkg::stageTimeT  tNewM
);
    import hazardPkg::*;

    stageTimeT expectTNewM;

    // Execute Tnew, one stage closer
    assign expectTNewM = (tNewE == 2'd0) ? 2'd0 : tNewE - 2'd1;

    //////////////////////////////////////////////////////////////////////
    // Pipeline control outputs
    //////////////////////////////////////////////////////////////////////
    pcIfIdAgree: assert property (@(posedge clk) pcWrite == ifIdEn)
        else $error("pcWrite %b and ifIdEn %b disagree", pcWrite, ifIdEn);

    clrInvertsPc: assert property (@(posedge clk) idExClr == !pcWrite)
        else $error("idExClr %b is not the inverse of pcWrite %b", idExClr, pcWrite);

    //////////////////////////////////////////////////////////////////////
    // Memory-stage producer record
    //////////////////////////////////////////////////////////////////////
    memClearAfterReset: assert property (@(posedge clk) $past(rst) |-> tNewM == 2'd0)
        else $error("tNewM is %0d in the cycle after reset", tNewM);

    memFollowsExec: assert property (@(posedge clk) disable iff (rst)
        !$past(rst) |-> tNewM == $past(expectTNewM))
        else $error("tNewM %0d does not follow the previous tNewE", tNewM);

endmodule

//--- hazardUnit.sv
`timescale 1ns/1ns

module hazardUnit (
    input  logic                  clk,
    input  logic                  rst,
    input  hazardPkg::instrT      instrD,
    input  hazardPkg::instrT      instrE,
    input  logic                  regWriteE,
    input  logic                  regWriteM,
    input  logic                  mduBusy,
    input  logic                  mduStart,
    output logic                  pcWrite,
    output logic                  ifIdEn,
    output logic                  idExClr,
    output logic                  mduClr,
    output hazardPkg::regNumT     useRs,
    output hazardPkg::regNumT     useRt,
    output hazardPkg::stageTimeT  tNewE,
    output hazardPkg::stageTimeT  tNewM
);
    import hazardPkg::*;

    stageTimeT  tUseRs;
    stageTimeT  tUseRt;
    regNumT     newE;
    regNumT     newM;
    instrClassT decodeClass;

    //////////////////////////////////////////////////////////////////////
    // Consumer side
    //////////////////////////////////////////////////////////////////////
    hazardDecode decodeStage (
        .instrD      (instrD),
        .useRs       (useRs),
        .useRt       (useRt),
        .tUseRs      (tUseRs),
        .tUseRt      (tUseRt),
        .decodeClass (decodeClass)
    );

    //////////////////////////////////////////////////////////////////////
    // Producer side, execute and memory
    //////////////////////////////////////////////////////////////////////
    hazardExecute executeStage (
        .clk    (clk),
        .rst    (rst),
        .instrE (instrE),
        .newE   (newE),
        .newM   (newM),
        .tNewE  (tNewE),
        .tNewM  (tNewM)
    );

    hazardResult result (
        .useRs       (useRs),
        .useRt       (useRt),
        .newE        (newE),
        .newM        (newM),
        .tUseRs      (tUseRs),
        .tUseRt      (tUseRt),
        .tNewE       (tNewE),
        .tNewM       (tNewM),
        .decodeClass (decodeClass),
        .regWriteE   (regWriteE),
        .regWriteM   (regWriteM),
        .mduBusy     (mduBusy),
        .mduStart    (mduStart),
        .pcWrite     (pcWrite),
        .ifIdEn      (ifIdEn),
        .idExClr     (idExClr),
        .mduClr      (mduClr)
    );

endmodule

//--- hazardResult.sv
`timescale 1ns/1ns

module hazardResult (
    input  hazardPkg::regNumT      useRs,
    input  hazardPkg::regNumT      useRt,
    input  hazardPkg::regNumT      newE,
    input  hazardPkg::regNumT      newM,
    input  hazardPkg::stageTimeT   tUseRs,
    input  hazardPkg::stageTimeT   tUseRt,
    input  hazardPkg::stageTimeT   tNewE,
    input  hazardPkg::stageTimeT   tNewM,
    input  hazardPkg::instrClassT  decodeClass,
    input  logic                   regWriteE,
    input  logic                   regWriteM,
    input  logic                   mduBusy,
    input  logic                   mduStart,
    output logic                   pcWrite,
    output logic                   ifIdEn,
    output logic                   idExClr,
    output logic                   mduClr
);
    import hazardPkg::*;

    logic dataStall;
    logic mduActive;
    logic hiLoAccess;
    logic mduStall;
    logic stall;

    // One source against one producer stage
    function automatic logic depStall(input regNumT useNum, input stageTimeT tUse,
                                      input regNumT newNum, input stageTimeT tNew,
                                      input logic writeEn);
        return (useNum == newNum) && (useNum != '0) && writeEn && (tUse < tNew);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Stall conditions
    //////////////////////////////////////////////////////////////////////
    assign dataStall = depStall(useRs, tUseRs, newE, tNewE, regWriteE)
                     | depStall(useRs, tUseRs, newM, tNewM, regWriteM)
                     | depStall(useRt, tUseRt, newE, tNewE, regWriteE)
                     | depStall(useRt, tUseRt, newM, tNewM, regWriteM);

    assign mduActive  = mduBusy | mduStart;
    assign hiLoAccess = decodeClass inside {hiLoRead, hiLoWrite, mduMultc};
    assign mduStall   = mduActive & hiLoAccess;
    assign stall      = dataStall | mduStall;

    assign pcWrite = ~stall;
    assign ifIdEn  = ~stall;
    assign idExClr = stall;

    // The port shadows the class label, so the label is scoped here
    assign mduClr = mduActive & (decodeClass == hazardPkg::mduStart);

endmodule

//--- hazardExecute.sv
`timescale 1ns/1ns
`include "hazard_defines.svh"

module hazardExecute (
    input  logic                  clk,
    input  logic                  rst,
    input  hazardPkg::instrT      instrE,
    output hazardPkg::regNumT     newE,
    output hazardPkg::regNumT     newM,
    output hazardPkg::stageTimeT  tNewE,
    output hazardPkg::stageTimeT  tNewM
);
    import hazardPkg::*;

    regNumT     rtField;
    regNumT     rdField;
    instrClassT execClass;

    assign rtField   = instrE[20:16];
    assign rdField   = instrE[15:11];
    assign execClass = classify(instrE);

    //////////////////////////////////////////////////////////////////////
    // Produce table for the instruction in execute
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        case (execClass)
            aluReg, hiLoRead: begin
                newE  = rdField;
                tNewE = 2'd1;
            end
            aluImm, lui: begin
                newE  = rtField;
                tNewE = 2'd1;
            end
            load: begin
                // Data returns at the end of MEM
                newE  = rtField;
                tNewE = 2'd2;
            end
            jal: begin
                // Link value is ready from the PC path
                newE  = `LINK_REG;
                tNewE = 2'd0;
            end
            default: begin
                newE  = '0;
                tNewE = 2'd0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Memory-stage producer record
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            newM  <= `MEM_RESET_REG;
            tNewM <= `MEM_RESET_TIME;
        end else begin
            newM <= newE;
            // One stage closer, never below zero
            if (tNewE == 2'd0) begin
                tNewM <= 2'd0;
            end else begin
                tNewM <= tNewE - 2'd1;
            end
        end
    end

endmodule

//--- hazardDecode.sv
`timescale 1ns/1ns

module hazardDecode (
    input  hazardPkg::instrT       instrD,
    output hazardPkg::regNumT      useRs,
    output hazardPkg::regNumT      useRt,
    output hazardPkg::stageTimeT   tUseRs,
    output hazardPkg::stageTimeT   tUseRt,
    output hazardPkg::instrClassT  decodeClass
);
    import hazardPkg::*;

    regNumT rsField;
    regNumT rtField;

    assign rsField     = instrD[25:21];
    assign rtField     = instrD[20:16];
    assign decodeClass = classify(instrD);

    //////////////////////////////////////////////////////////////////////
    // Use table
    //////////////////////////////////////////////////////////////////////
    always_comb begin
        // Unread sources report register 0
        useRs  = '0;
        useRt  = '0;
        tUseRs = 2'd0;
        tUseRt = 2'd0;
        case (decodeClass)
            aluReg, mduStart, mduMultc: begin
                useRs  = rsField;
                tUseRs = 2'd1;
                useRt  = rtField;
                tUseRt = 2'd1;
            end
            aluImm, load, hiLoWrite: begin
                useRs  = rsField;
                tUseRs = 2'd1;
            end
            store: begin
                // Base address needed in EX, store data not until MEM
                useRs  = rsField;
                tUseRs = 2'd1;
                useRt  = rtField;
                tUseRt = 2'd2;
            end
            branch: begin
                // Compared in decode
                useRs  = rsField;
                tUseRs = 2'd0;
                useRt  = rtField;
                tUseRt = 2'd0;
            end
            jumpReg: begin
                useRs  = rsField;
                tUseRs = 2'd0;
            end
            default: begin
                useRs  = '0;
                useRt  = '0;
                tUseRs = 2'd0;
                tUseRt = 2'd0;
            end
        endcase
    end

endmodule

//--- hazardPkg.sv
`include "hazard_defines.svh"

package hazardPkg;

    typedef logic [31:0] instrT;
    typedef logic [4:0]  regNumT;
    typedef logic [1:0]  stageTimeT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;

    // Shared by decode and execute
    typedef enum logic [3:0] {
        aluReg,
        aluImm,
        lui,
        store,
        load,
        mduStart,
        hiLoRead,
        hiLoWrite,
        mduMultc,
        branch,
        jal,
        jump,
        jumpReg,
        other
    } instrClassT;

    //////////////////////////////////////////////////////////////////////
    // Instruction classification
    //////////////////////////////////////////////////////////////////////
    function automatic instrClassT classify(input instrT instr);
        opcodeT     op;
        functT      fn;
        instrClassT cls;
        op  = instr[31:26];
        fn  = instr[5:0];
        cls = other;
        case (op)
            `OP_RTYPE: begin
                // Funct only matters for R-type
                case (fn)
                    `FN_ADD, `FN_SUB, `FN_AND,
                    `FN_OR, `FN_SLT, `FN_SLTU:     cls = aluReg;
                    `FN_MULT, `FN_MULTU,
                    `FN_DIV, `FN_DIVU:             cls = mduStart;
                    `FN_MFHI, `FN_MFLO:            cls = hiLoRead;
                    `FN_MTHI, `FN_MTLO:            cls = hiLoWrite;
                    `FN_MULTC:                     cls = mduMultc;
                    `FN_JR:                        cls = jumpReg;
                    default:                       cls = other;
                endcase
            end
            `OP_ORI, `OP_ADDI, `OP_ANDI:           cls = aluImm;
            `OP_LUI:                               cls = lui;
            `OP_SW, `OP_SB, `OP_SH:                cls = store;
            `OP_LW, `OP_LB, `OP_LH:                cls = load;
            `OP_BEQ, `OP_BNE:                      cls = branch;
            `OP_JAL:                               cls = jal;
            `OP_J:                                 cls = jump;
            default:                               cls = other;
        endcase
        return cls;
    endfunction

endpackage

//--- hazard_defines.svh
`ifndef HAZARD_DEFINES_SVH
`define HAZARD_DEFINES_SVH

//////////////////////////////////////////////////////////////////////
// Primary opcodes
//////////////////////////////////////////////////////////////////////
`define OP_RTYPE    6'b000000
`define OP_ORI      6'b001101
`define OP_ADDI     6'b001000
`define OP_ANDI     6'b001100
`define OP_LUI      6'b001111
`define OP_SW       6'b101011
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_LW       6'b100011
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_JAL      6'b000011
`define OP_J        6'b000010

//////////////////////////////////////////////////////////////////////
// Funct codes for the R-type opcode
//////////////////////////////////////////////////////////////////////
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_MFHI     6'b010000
`define FN_MFLO     6'b010010
`define FN_MTHI     6'b010001
`define FN_MTLO     6'b010011
// Custom multiply-compare, not part of the base set
`define FN_MULTC    6'b011100
`define FN_JR       6'b001000

// Return address register written by jal
`define LINK_REG    5'd31

// Memory-stage producer record after reset
`define MEM_RESET_REG   5'd0
`define MEM_RESET_TIME  2'd0

`endif
